// File: bank_arbiter.sv
// Round-robin arbiter of one VRF bank whose high group masks the low group; the top has one per bank
`timescale 1ns/1ps
`include "vrf_access_consts.svh"

module bank_arbiter (
  input  logic                                   clk_i,
  input  logic                                   rst_ni,
  // Requests, indexed by master
  input  logic [3:0]                             req_i,
  input  logic [`VRF_ADDR_W-`VRF_BANK_IDX_W-1:0] rd_row_a_i,
  input  logic [`VRF_ADDR_W-`VRF_BANK_IDX_W-1:0] rd_row_b_i,
  input  logic [`VRF_ADDR_W-`VRF_BANK_IDX_W-1:0] wr_row_alu_i,
  input  logic [`VRF_ADDR_W-`VRF_BANK_IDX_W-1:0] wr_row_ldu_i,
  input  logic [`VRF_WORD_W-1:0]                 wdata_alu_i,
  input  logic [`VRF_WORD_W-1:0]                 wdata_ldu_i,
  input  logic [`VRF_BE_W-1:0]                   be_alu_i,
  input  logic [`VRF_BE_W-1:0]                   be_ldu_i,
  output logic [3:0]                             gnt_o,
  // Bank port
  output logic                                   vrf_req_o,
  output logic [`VRF_ADDR_W-`VRF_BANK_IDX_W-1:0] vrf_addr_o,
  output logic                                   vrf_wen_o,
  output logic [`VRF_WORD_W-1:0]                 vrf_wdata_o,
  output logic [`VRF_BE_W-1:0]                   vrf_be_o,
  output vrf_access_pkg::opqueue_e               vrf_tgt_o
);

  // Set when the write master is next in line within its group
  logic rr_hi_q;
  logic rr_lo_q;
  logic hi_any;
  logic hi_contend;
  logic lo_contend;

  assign hi_any     = req_i[vrf_access_pkg::MST_OPQ_A] | req_i[vrf_access_pkg::MST_ALU];
  assign hi_contend = req_i[vrf_access_pkg::MST_OPQ_A] & req_i[vrf_access_pkg::MST_ALU];
  assign lo_contend = !hi_any &&
                      req_i[vrf_access_pkg::MST_OPQ_B] && req_i[vrf_access_pkg::MST_LDU];

  ////////////////////////////////////////////////////////////////////////////
  // Grants
  ////////////////////////////////////////////////////////////////////////////

  assign gnt_o[vrf_access_pkg::MST_OPQ_A] = req_i[vrf_access_pkg::MST_OPQ_A] &&
                                            (!req_i[vrf_access_pkg::MST_ALU] || !rr_hi_q);
  assign gnt_o[vrf_access_pkg::MST_ALU]   = req_i[vrf_access_pkg::MST_ALU] &&
                                            (!req_i[vrf_access_pkg::MST_OPQ_A] || rr_hi_q);
  // Low group only sees the bank when the high group is silent
  assign gnt_o[vrf_access_pkg::MST_OPQ_B] = !hi_any && req_i[vrf_access_pkg::MST_OPQ_B] &&
                                            (!req_i[vrf_access_pkg::MST_LDU] || !rr_lo_q);
  assign gnt_o[vrf_access_pkg::MST_LDU]   = !hi_any && req_i[vrf_access_pkg::MST_LDU] &&
                                            (!req_i[vrf_access_pkg::MST_OPQ_B] || rr_lo_q);

  // Every request wins somewhere, and the bank answers at once
  assign vrf_req_o = |req_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rr_hi_q <= 1'b0;
      rr_lo_q <= 1'b0;
    end else begin
      if (hi_contend) begin
        rr_hi_q <= !rr_hi_q;
      end
      if (lo_contend) begin
        rr_lo_q <= !rr_lo_q;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Winner payload
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    vrf_addr_o  = '0;
    vrf_wen_o   = 1'b0;
    vrf_wdata_o = '0;
    vrf_be_o    = '0;
    vrf_tgt_o   = vrf_access_pkg::OPQ_A;
    if (gnt_o[vrf_access_pkg::MST_OPQ_A]) begin
      vrf_addr_o = rd_row_a_i;
    end else if (gnt_o[vrf_access_pkg::MST_ALU]) begin
      vrf_addr_o  = wr_row_alu_i;
      vrf_wen_o   = 1'b1;
      vrf_wdata_o = wdata_alu_i;
      vrf_be_o    = be_alu_i;
    end else if (gnt_o[vrf_access_pkg::MST_OPQ_B]) begin
      vrf_addr_o = rd_row_b_i;
      vrf_tgt_o  = vrf_access_pkg::OPQ_B;
    end else if (gnt_o[vrf_access_pkg::MST_LDU]) begin
      vrf_addr_o  = wr_row_ldu_i;
      vrf_wen_o   = 1'b1;
      vrf_wdata_o = wdata_ldu_i;
      vrf_be_o    = be_ldu_i;
    end
  end

  a_gnt_onehot: assert property (@(posedge clk_i) disable iff (!rst_ni) $onehot0(gnt_o))
    else $error("bank_arbiter: more than one grant");

endmodule

// File: operand_requester.sv
// Operand requester for one queue: takes a read command and streams banked VRF read requests
`timescale 1ns/1ps
`include "vrf_access_consts.svh"

module operand_requester (
  input  logic                                   clk_i,
  input  logic                                   rst_ni,
  // Read command
  input  logic                                   opreq_valid_i,
  input  logic [`VRF_VS_W-1:0]                   opreq_vs_i,
  input  logic [`VRF_LEN_W-1:0]                  opreq_vstart_i,
  input  logic [`VRF_LEN_W-1:0]                  opreq_len_i,
  output logic                                   opreq_ready_o,
  // Operand queue
  input  logic                                   opq_ready_i,
  output logic                                   operand_issued_o,
  // Bank arbiters
  output logic [`VRF_NR_BANKS-1:0]               bank_req_o,
  output logic [`VRF_ADDR_W-`VRF_BANK_IDX_W-1:0] row_addr_o,
  input  logic [`VRF_NR_BANKS-1:0]               bank_gnt_i
);

  vrf_access_pkg::req_state_e state_d, state_q;
  logic [`VRF_ADDR_W-1:0]     addr_d, addr_q;
  logic [`VRF_LEN_W-1:0]      len_d, len_q;
  logic [`VRF_ADDR_W-1:0]     cmd_addr;
  logic                       granted;
  logic                       last_gnt;
  logic                       accept;

  // First word of the command: register base plus start offset
  assign cmd_addr = `VRF_ADDR_W'(opreq_vs_i * `VRF_REG_WORDS + opreq_vstart_i);

  // Only one bank is requested, so any grant is ours
  assign granted          = |bank_gnt_i;
  assign operand_issued_o = granted;

  // Last word granted this cycle frees the requester for a new command
  assign last_gnt = (state_q == vrf_access_pkg::REQ_ACTIVE) && granted &&
                    (len_q == `VRF_LEN_W'(1));
  assign opreq_ready_o = (state_q == vrf_access_pkg::REQ_IDLE) || last_gnt;
  assign accept        = opreq_valid_i && opreq_ready_o;

  assign row_addr_o = addr_q[`VRF_ADDR_W-1:`VRF_BANK_IDX_W];

  ////////////////////////////////////////////////////////////////////////////
  // Bank request
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    bank_req_o = '0;
    // Stalled queue holds the position, nothing is requested
    if (state_q == vrf_access_pkg::REQ_ACTIVE && opq_ready_i) begin
      bank_req_o[addr_q[`VRF_BANK_IDX_W-1:0]] = 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Address and count
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    addr_d  = addr_q;
    len_d   = len_q;

    // Step to the next word on every grant
    if (granted) begin
      addr_d = addr_q + 1'b1;
      len_d  = len_q - 1'b1;
      if (len_q == `VRF_LEN_W'(1)) begin
        state_d = vrf_access_pkg::REQ_IDLE;
      end
    end

    // New command, also back-to-back in the last grant cycle
    if (accept) begin
      addr_d = cmd_addr;
      len_d  = opreq_len_i;
      if (opreq_len_i == '0) begin
        state_d = vrf_access_pkg::REQ_IDLE;  // nothing to read
      end else begin
        state_d = vrf_access_pkg::REQ_ACTIVE;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= vrf_access_pkg::REQ_IDLE;
      addr_q  <= '0;
      len_q   <= '0;
    end else begin
      state_q <= state_d;
      addr_q  <= addr_d;
      len_q   <= len_d;
    end
  end

  // Requests target one bank at a time
  a_one_bank: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $onehot0(bank_req_o))
    else $error("operand_requester: several banks requested");

  // Arbiters only answer the bank that was asked for
  a_gnt_has_req: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (bank_gnt_i & ~bank_req_o) == '0)
    else $error("operand_requester: grant without request");

endmodule

// File: result_stream_reg.sv
// One-entry valid/ready register that decouples the load-unit write port from the arbiters
`timescale 1ns/1ps
`include "vrf_access_consts.svh"

module result_stream_reg (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  // Upstream side
  input  logic                   valid_i,
  input  logic [`VRF_ADDR_W-1:0] addr_i,
  input  logic [`VRF_WORD_W-1:0] wdata_i,
  input  logic [`VRF_BE_W-1:0]   be_i,
  output logic                   ready_o,
  // Downstream side
  output logic                   valid_o,
  output logic [`VRF_ADDR_W-1:0] addr_o,
  output logic [`VRF_WORD_W-1:0] wdata_o,
  output logic [`VRF_BE_W-1:0]   be_o,
  input  logic                   ready_i
);

  logic valid_q;
  logic load;

  // Free when empty or drained in this cycle
  assign ready_o = !valid_q || ready_i;
  assign load    = valid_i && ready_o;
  assign valid_o = valid_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
    end else if (ready_o) begin
      valid_q <= valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (load) begin
      addr_o  <= addr_i;
      wdata_o <= wdata_i;
      be_o    <= be_i;
    end
  end

  // Word waiting for a grant is held as it is
  a_hold_payload: assert property (@(posedge clk_i) disable iff (!rst_ni)
    valid_o && !ready_i |=> valid_o && $stable({addr_o, wdata_o, be_o}))
    else $error("result_stream_reg: payload changed while stalled");

endmodule

// File: tb_vrf_access.sv
// Testbench of the VRF access stage: applies a table of commands and writes against a cycle model
`timescale 1ns/1ps
`include "vrf_access_consts.svh"

module tb_vrf_access;

  localparam int NR_ROWS = 6;
  localparam int ROW_W   = `VRF_ADDR_W - `VRF_BANK_IDX_W;

  // Two commands per requester, the second starts where the first ends
  typedef struct packed {
    logic [`VRF_VS_W-1:0]   a_vs;
    logic [`VRF_LEN_W-1:0]  a_vstart, a_len, a_len2;
    logic [`VRF_VS_W-1:0]   b_vs;
    logic [`VRF_LEN_W-1:0]  b_vstart, b_len, b_len2;
    logic [3:0]             alu_n;
    logic [`VRF_ADDR_W-1:0] alu_addr;
    logic [3:0]             ldu_n;
    logic [`VRF_ADDR_W-1:0] ldu_addr;
    logic                   opq_rand;
    logic [7:0]             cycles;
    logic [7:0]             exp_a, exp_b;
  } row_t;

  logic clk_i, rst_ni;
  logic opreq_valid_a_i, opreq_ready_a_o, opq_ready_a_i, operand_issued_a_o;
  logic opreq_valid_b_i, opreq_ready_b_o, opq_ready_b_i, operand_issued_b_o;
  logic [`VRF_VS_W-1:0]  opreq_vs_a_i, opreq_vs_b_i;
  logic [`VRF_LEN_W-1:0] opreq_vstart_a_i, opreq_len_a_i, opreq_vstart_b_i, opreq_len_b_i;
  logic alu_req_i, alu_gnt_o, ldu_req_i, ldu_gnt_o;
  logic [`VRF_ADDR_W-1:0] alu_addr_i, ldu_addr_i;
  logic [`VRF_WORD_W-1:0] alu_wdata_i, ldu_wdata_i;
  logic [`VRF_BE_W-1:0]   alu_be_i, ldu_be_i;
  logic [`VRF_NR_BANKS-1:0]                   vrf_req_o, vrf_wen_o;
  logic [`VRF_NR_BANKS-1:0][ROW_W-1:0]        vrf_addr_o;
  logic [`VRF_NR_BANKS-1:0][`VRF_WORD_W-1:0]  vrf_wdata_o;
  logic [`VRF_NR_BANKS-1:0][`VRF_BE_W-1:0]    vrf_be_o;
  vrf_access_pkg::opqueue_e [`VRF_NR_BANKS-1:0] vrf_tgt_o;

  // Reference model state
  logic [`VRF_ADDR_W-1:0]   ma_addr, mb_addr, ml_addr;
  logic [`VRF_LEN_W-1:0]    ma_len, mb_len;
  logic                     ma_act, mb_act, ml_valid;
  logic [`VRF_WORD_W-1:0]   ml_data;
  logic [`VRF_BE_W-1:0]     ml_be;
  logic [`VRF_NR_BANKS-1:0] rr_hi, rr_lo;
  logic [31:0]              lfsr;
  logic                     alu_fresh, ldu_fresh, done;
  int a_cmds, b_cmds, alu_left, ldu_left, cnt_a, cnt_b, errors, row_err, cycle;
  row_t rows [NR_ROWS];

  vrf_access_top dut (.*);

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  // Galois LFSR, one step per bit taken
  function automatic logic [63:0] lfsr_bits(input int n);
    logic [63:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
      v    = {v[62:0], lfsr[0]};
    end
    return v;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Compare tasks
  ////////////////////////////////////////////////////////////////////////////

  task automatic report_mismatch(input string name, input logic [63:0] exp, input logic [63:0] got);
    $display("Mismatch %s at %0t: expected %h, got %h", name, $time, exp, got);
    errors++;
  endtask

  task automatic check_bank(input int b, input logic req, input logic [ROW_W-1:0] addr,
                            input logic wen, input logic [`VRF_WORD_W-1:0] wdata,
                            input logic [`VRF_BE_W-1:0] be, input vrf_access_pkg::opqueue_e tgt);
    if (vrf_req_o[b] !== req) report_mismatch($sformatf("vrf_req_o[%0d]", b), req, vrf_req_o[b]);
    // Payload only matters on a request
    if (req) begin
      if (vrf_addr_o[b] !== addr)
        report_mismatch($sformatf("vrf_addr_o[%0d]", b), addr, vrf_addr_o[b]);
      if (vrf_wen_o[b] !== wen) report_mismatch($sformatf("vrf_wen_o[%0d]", b), wen, vrf_wen_o[b]);
      if (vrf_wdata_o[b] !== wdata)
        report_mismatch($sformatf("vrf_wdata_o[%0d]", b), wdata, vrf_wdata_o[b]);
      if (vrf_be_o[b] !== be) report_mismatch($sformatf("vrf_be_o[%0d]", b), be, vrf_be_o[b]);
      if (vrf_tgt_o[b] !== tgt) report_mismatch($sformatf("vrf_tgt_o[%0d]", b), tgt, vrf_tgt_o[b]);
    end
  endtask

  task automatic check_gnt(input string name, input logic exp, input logic got);
    if (got !== exp) report_mismatch(name, exp, got);
  endtask

  task automatic check_count(input string name, input int exp, input int got);
    if (got != exp) report_mismatch(name, exp, got);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Cycle model
  ////////////////////////////////////////////////////////////////////////////

  task automatic step_requester(input logic gnt, input logic valid, input logic [`VRF_VS_W-1:0] vs,
                                input logic [`VRF_LEN_W-1:0] vstart, input logic [`VRF_LEN_W-1:0] len,
                                inout logic act, inout logic [`VRF_ADDR_W-1:0] addr,
                                inout logic [`VRF_LEN_W-1:0] left, output logic rdy,
                                output logic acc);
    rdy = !act || (gnt && left == 1);
    acc = valid && rdy;
    if (gnt) begin
      addr = addr + 1'b1;
      left = left - 1'b1;
      if (left == 0) act = 1'b0;
    end
    if (acc) begin
      addr = vs * `VRF_REG_WORDS + vstart;
      left = len;
      act  = (len != 0);
    end
  endtask

  task automatic model_cycle();
    logic [3:0]             req [`VRF_NR_BANKS];
    logic [3:0]             win;
    logic                   a_gnt, b_gnt, alu_won, ldu_won, rdy_a, rdy_b, rdy_l, a_acc, b_acc;
    logic                   ex_wen;
    logic [ROW_W-1:0]       ex_addr;
    logic [`VRF_WORD_W-1:0] ex_wd;
    logic [`VRF_BE_W-1:0]   ex_be;
    vrf_access_pkg::opqueue_e ex_tgt;
    for (int b = 0; b < `VRF_NR_BANKS; b++) req[b] = '0;
    if (ma_act && opq_ready_a_i) req[ma_addr[1:0]][vrf_access_pkg::MST_OPQ_A] = 1'b1;
    if (alu_req_i) req[alu_addr_i[1:0]][vrf_access_pkg::MST_ALU] = 1'b1;
    if (mb_act && opq_ready_b_i) req[mb_addr[1:0]][vrf_access_pkg::MST_OPQ_B] = 1'b1;
    if (ml_valid) req[ml_addr[1:0]][vrf_access_pkg::MST_LDU] = 1'b1;
    {a_gnt, b_gnt, alu_won, ldu_won} = '0;
    for (int b = 0; b < `VRF_NR_BANKS; b++) begin
      win = '0;
      // Bits 1:0 are the high group, 3:2 the low group
      if (req[b][1:0] == 2'b11) begin
        win[rr_hi[b] ? vrf_access_pkg::MST_ALU : vrf_access_pkg::MST_OPQ_A] = 1'b1;
        rr_hi[b] = !rr_hi[b];
      end else if (req[b][1:0] != 2'b00) begin
        win = req[b] & 4'b0011;
      end else if (req[b][3:2] == 2'b11) begin
        win[rr_lo[b] ? vrf_access_pkg::MST_LDU : vrf_access_pkg::MST_OPQ_B] = 1'b1;
        rr_lo[b] = !rr_lo[b];
      end else begin
        win = req[b];
      end
      ex_addr = '0;
      ex_wen  = 1'b0;
      ex_wd   = '0;
      ex_be   = '0;
      ex_tgt  = vrf_access_pkg::OPQ_A;
      if (win[vrf_access_pkg::MST_OPQ_A]) begin
        ex_addr = ma_addr[`VRF_ADDR_W-1:`VRF_BANK_IDX_W];
      end else if (win[vrf_access_pkg::MST_ALU]) begin
        {ex_addr, ex_wen} = {alu_addr_i[`VRF_ADDR_W-1:`VRF_BANK_IDX_W], 1'b1};
        {ex_wd, ex_be}    = {alu_wdata_i, alu_be_i};
      end else if (win[vrf_access_pkg::MST_OPQ_B]) begin
        ex_addr = mb_addr[`VRF_ADDR_W-1:`VRF_BANK_IDX_W];
        ex_tgt  = vrf_access_pkg::OPQ_B;
      end else if (win[vrf_access_pkg::MST_LDU]) begin
        {ex_addr, ex_wen} = {ml_addr[`VRF_ADDR_W-1:`VRF_BANK_IDX_W], 1'b1};
        {ex_wd, ex_be}    = {ml_data, ml_be};
      end
      check_bank(b, |win, ex_addr, ex_wen, ex_wd, ex_be, ex_tgt);
      a_gnt   |= win[vrf_access_pkg::MST_OPQ_A];
      alu_won |= win[vrf_access_pkg::MST_ALU];
      b_gnt   |= win[vrf_access_pkg::MST_OPQ_B];
      ldu_won |= win[vrf_access_pkg::MST_LDU];
    end
    step_requester(a_gnt, opreq_valid_a_i, opreq_vs_a_i, opreq_vstart_a_i, opreq_len_a_i,
                   ma_act, ma_addr, ma_len, rdy_a, a_acc);
    step_requester(b_gnt, opreq_valid_b_i, opreq_vs_b_i, opreq_vstart_b_i, opreq_len_b_i,
                   mb_act, mb_addr, mb_len, rdy_b, b_acc);
    rdy_l = !ml_valid || ldu_won;
    check_gnt("alu_gnt_o", alu_won, alu_gnt_o);
    check_gnt("ldu_gnt_o", rdy_l, ldu_gnt_o);
    check_gnt("operand_issued_a_o", a_gnt, operand_issued_a_o);
    check_gnt("operand_issued_b_o", b_gnt, operand_issued_b_o);
    check_gnt("opreq_ready_a_o", rdy_a, opreq_ready_a_o);
    check_gnt("opreq_ready_b_o", rdy_b, opreq_ready_b_o);
    cnt_a += operand_issued_a_o;
    cnt_b += operand_issued_b_o;
    // Stream register takes a word when empty or drained
    if (ldu_req_i && rdy_l) begin
      {ml_addr, ml_data, ml_be} = {ldu_addr_i, ldu_wdata_i, ldu_be_i};
      ldu_left--;
      ldu_fresh = 1'b1;
    end
    if (rdy_l) ml_valid = ldu_req_i;
    if (a_acc) a_cmds--;
    if (b_acc) b_cmds--;
    if (alu_won) begin
      alu_left--;
      alu_fresh = 1'b1;
    end
  endtask

  task automatic drive_inputs(input row_t r);
    opreq_valid_a_i  <= (a_cmds > 0);
    opreq_vs_a_i     <= r.a_vs;
    opreq_vstart_a_i <= (a_cmds == 2) ? r.a_vstart : r.a_vstart + r.a_len;
    opreq_len_a_i    <= (a_cmds == 2) ? r.a_len : r.a_len2;
    opreq_valid_b_i  <= (b_cmds > 0);
    opreq_vs_b_i     <= r.b_vs;
    opreq_vstart_b_i <= (b_cmds == 2) ? r.b_vstart : r.b_vstart + r.b_len;
    opreq_len_b_i    <= (b_cmds == 2) ? r.b_len : r.b_len2;
    alu_req_i  <= (alu_left > 0);
    alu_addr_i <= r.alu_addr;
    ldu_req_i  <= (ldu_left > 0);
    ldu_addr_i <= r.ldu_addr;
    if (alu_fresh) begin
      alu_wdata_i <= lfsr_bits(64);
      alu_be_i    <= `VRF_BE_W'(lfsr_bits(8));
      alu_fresh = 1'b0;
    end
    if (ldu_fresh) begin
      ldu_wdata_i <= lfsr_bits(64);
      ldu_be_i    <= `VRF_BE_W'(lfsr_bits(8));
      ldu_fresh = 1'b0;
    end
    opq_ready_a_i <= !r.opq_rand || (lfsr_bits(1) != '0);
    opq_ready_b_i <= !r.opq_rand || (lfsr_bits(1) != '0);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus table and run
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    rows[0] = '{5'd2, 8'd1, 8'd6, 8'd0, 5'd0, 8'd0, 8'd0, 8'd0, 4'd0, 8'h00, 4'd0, 8'h00,
                1'b1, 8'd30, 8'd6, 8'd0};
    rows[1] = '{5'd0, 8'd0, 8'd0, 8'd0, 5'd0, 8'd0, 8'd0, 8'd0, 4'd2, 8'h05, 4'd2, 8'h0a,
                1'b0, 8'd10, 8'd0, 8'd0};
    rows[2] = '{5'd0, 8'd4, 8'd4, 8'd0, 5'd0, 8'd0, 8'd0, 8'd0, 4'd0, 8'h00, 4'd1, 8'h20,
                1'b0, 8'd12, 8'd4, 8'd0};
    rows[3] = '{5'd1, 8'd0, 8'd8, 8'd0, 5'd0, 8'd0, 8'd0, 8'd0, 4'd6, 8'h04, 4'd0, 8'h00,
                1'b0, 8'd24, 8'd8, 8'd0};
    rows[4] = '{5'd0, 8'd0, 8'd0, 8'd0, 5'd3, 8'd0, 8'd8, 8'd0, 4'd0, 8'h00, 4'd6, 8'h30,
                1'b0, 8'd24, 8'd0, 8'd8};
    rows[5] = '{5'd4, 8'd2, 8'd0, 8'd3, 5'd5, 8'd0, 8'd2, 8'd2, 4'd0, 8'h00, 4'd0, 8'h00,
                1'b0, 8'd16, 8'd3, 8'd4};
    {opreq_valid_a_i, opreq_vs_a_i, opreq_vstart_a_i, opreq_len_a_i, opq_ready_a_i} = '0;
    {opreq_valid_b_i, opreq_vs_b_i, opreq_vstart_b_i, opreq_len_b_i, opq_ready_b_i} = '0;
    {alu_req_i, alu_addr_i, alu_wdata_i, alu_be_i} = '0;
    {ldu_req_i, ldu_addr_i, ldu_wdata_i, ldu_be_i} = '0;
    {ma_act, mb_act, ml_valid, ma_addr, mb_addr, ma_len, mb_len} = '0;
    {ml_addr, ml_data, ml_be, rr_hi, rr_lo} = '0;
    lfsr   = 32'he847;
    errors = 0;
    rst_ni = 1'b0;
    repeat (2) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(negedge clk_i);
    check_gnt("vrf_req_o", 1'b0, |vrf_req_o);
    check_gnt("opreq_ready_a_o", 1'b1, opreq_ready_a_o);
    check_gnt("opreq_ready_b_o", 1'b1, opreq_ready_b_o);
    check_gnt("ldu_gnt_o", 1'b1, ldu_gnt_o);
    $display("Reset check finished with %0d errors", errors);
    for (int t = 0; t < NR_ROWS; t++) begin
      row_err   = errors;
      a_cmds    = 2;
      b_cmds    = 2;
      alu_left  = rows[t].alu_n;
      ldu_left  = rows[t].ldu_n;
      alu_fresh = 1'b1;
      ldu_fresh = 1'b1;
      {cnt_a, cnt_b, cycle, done} = '0;
      while (!done) begin
        @(posedge clk_i);
        drive_inputs(rows[t]);
        @(negedge clk_i);
        model_cycle();
        cycle++;
        done = (a_cmds == 0) && (b_cmds == 0) && !ma_act && !mb_act &&
               (alu_left == 0) && (ldu_left == 0) && !ml_valid;
      end
      check_count("operand_issued_a_o pulses", rows[t].exp_a, cnt_a);
      check_count("operand_issued_b_o pulses", rows[t].exp_b, cnt_b);
      $display("Test %0d finished after %0d cycles with %0d errors", t, cycle, errors - row_err);
    end
    $display("Tests run: %0d, errors: %0d", NR_ROWS, errors);
    if (errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

  // Watchdog sized from the table
  initial begin
    int budget;
    budget = 0;
    #1;
    foreach (rows[i]) budget += rows[i].cycles;
    #(budget * 20 * 10);
    $display("Timeout: the tests did not finish within %0d cycles", budget * 20);
    $display("Simulation FAILED");
    $finish;
  end

endmodule

// File: vrf_access.f
+incdir+.
vrf_access_pkg.sv
operand_requester.sv
result_stream_reg.sv
bank_arbiter.sv
vrf_access_top.sv
tb_vrf_access.sv

// File: vrf_access_consts.svh
// Sizes of the VRF banks, words and command fields; included by the RTL and the testbench
`ifndef VRF_ACCESS_CONSTS_SVH
`define VRF_ACCESS_CONSTS_SVH

////////////////////////////////////////////////////////////////////////////
// Bank geometry
////////////////////////////////////////////////////////////////////////////

// Number of banks, selected by the low address bits
`define VRF_NR_BANKS 4
`define VRF_BANK_IDX_W 2

// One word is one 64-bit element
`define VRF_WORD_W 64
`define VRF_BE_W 8

////////////////////////////////////////////////////////////////////////////
// Addressing and command fields
////////////////////////////////////////////////////////////////////////////

`define VRF_ADDR_W 8
`define VRF_REG_WORDS 8
`define VRF_VS_W 5
`define VRF_LEN_W 8

`endif

// File: vrf_access_pkg.sv
// Enumerated types of the VRF access stage, shared by the RTL and the testbench
package vrf_access_pkg;

  // Operand requester state
  typedef enum logic {
    REQ_IDLE,
    REQ_ACTIVE
  } req_state_e;

  // Operand queue a read word is delivered to
  typedef enum logic {
    OPQ_A,
    OPQ_B
  } opqueue_e;

  // Arbiter input index
  // The first two form the high group, the last two the low group
  typedef enum logic [1:0] {
    MST_OPQ_A,
    MST_ALU,
    MST_OPQ_B,
    MST_LDU
  } master_e;

endpackage

// File: vrf_access_top.sv
// VRF access stage: two operand requesters and two result writers sharing the VRF banks
`timescale 1ns/1ps
`include "vrf_access_consts.svh"

module vrf_access_top (
  input  logic                                                       clk_i,
  input  logic                                                       rst_ni,
  // Requester A
  input  logic                                                       opreq_valid_a_i,
  input  logic [`VRF_VS_W-1:0]                                       opreq_vs_a_i,
  input  logic [`VRF_LEN_W-1:0]                                      opreq_vstart_a_i,
  input  logic [`VRF_LEN_W-1:0]                                      opreq_len_a_i,
  output logic                                                       opreq_ready_a_o,
  input  logic                                                       opq_ready_a_i,
  output logic                                                       operand_issued_a_o,
  // Requester B
  input  logic                                                       opreq_valid_b_i,
  input  logic [`VRF_VS_W-1:0]                                       opreq_vs_b_i,
  input  logic [`VRF_LEN_W-1:0]                                      opreq_vstart_b_i,
  input  logic [`VRF_LEN_W-1:0]                                      opreq_len_b_i,
  output logic                                                       opreq_ready_b_o,
  input  logic                                                       opq_ready_b_i,
  output logic                                                       operand_issued_b_o,
  // ALU result
  input  logic                                                       alu_req_i,
  input  logic [`VRF_ADDR_W-1:0]                                     alu_addr_i,
  input  logic [`VRF_WORD_W-1:0]                                     alu_wdata_i,
  input  logic [`VRF_BE_W-1:0]                                       alu_be_i,
  output logic                                                       alu_gnt_o,
  // Load-unit result
  input  logic                                                       ldu_req_i,
  input  logic [`VRF_ADDR_W-1:0]                                     ldu_addr_i,
  input  logic [`VRF_WORD_W-1:0]                                     ldu_wdata_i,
  input  logic [`VRF_BE_W-1:0]                                       ldu_be_i,
  output logic                                                       ldu_gnt_o,
  // VRF banks
  output logic [`VRF_NR_BANKS-1:0]                                   vrf_req_o,
  output logic [`VRF_NR_BANKS-1:0][`VRF_ADDR_W-`VRF_BANK_IDX_W-1:0] vrf_addr_o,
  output logic [`VRF_NR_BANKS-1:0]                                   vrf_wen_o,
  output logic [`VRF_NR_BANKS-1:0][`VRF_WORD_W-1:0]                 vrf_wdata_o,
  output logic [`VRF_NR_BANKS-1:0][`VRF_BE_W-1:0]                   vrf_be_o,
  output vrf_access_pkg::opqueue_e [`VRF_NR_BANKS-1:0]               vrf_tgt_o
);

  logic [`VRF_NR_BANKS-1:0]               bank_req_a, bank_gnt_a;
  logic [`VRF_NR_BANKS-1:0]               bank_req_b, bank_gnt_b;
  logic [`VRF_ADDR_W-`VRF_BANK_IDX_W-1:0] row_a, row_b;
  logic [`VRF_NR_BANKS-1:0]               alu_gnt_bank, ldu_gnt_bank;
  // Load word after the stream register
  logic                                   ldu_q_valid, ldu_q_ready;
  logic [`VRF_ADDR_W-1:0]                 ldu_q_addr;
  logic [`VRF_WORD_W-1:0]                 ldu_q_wdata;
  logic [`VRF_BE_W-1:0]                   ldu_q_be;

  operand_requester i_requester_a (
    .clk_i, .rst_ni,
    .opreq_valid_i(opreq_valid_a_i), .opreq_vs_i(opreq_vs_a_i),
    .opreq_vstart_i(opreq_vstart_a_i), .opreq_len_i(opreq_len_a_i),
    .opreq_ready_o(opreq_ready_a_o), .opq_ready_i(opq_ready_a_i),
    .operand_issued_o(operand_issued_a_o), .bank_req_o(bank_req_a),
    .row_addr_o(row_a), .bank_gnt_i(bank_gnt_a)
  );

  operand_requester i_requester_b (
    .clk_i, .rst_ni,
    .opreq_valid_i(opreq_valid_b_i), .opreq_vs_i(opreq_vs_b_i),
    .opreq_vstart_i(opreq_vstart_b_i), .opreq_len_i(opreq_len_b_i),
    .opreq_ready_o(opreq_ready_b_o), .opq_ready_i(opq_ready_b_i),
    .operand_issued_o(operand_issued_b_o), .bank_req_o(bank_req_b),
    .row_addr_o(row_b), .bank_gnt_i(bank_gnt_b)
  );

  result_stream_reg i_ldu_stream_reg (
    .clk_i, .rst_ni,
    .valid_i(ldu_req_i), .addr_i(ldu_addr_i), .wdata_i(ldu_wdata_i), .be_i(ldu_be_i),
    .ready_o(ldu_gnt_o),
    .valid_o(ldu_q_valid), .addr_o(ldu_q_addr), .wdata_o(ldu_q_wdata), .be_o(ldu_q_be),
    .ready_i(ldu_q_ready)
  );

  ////////////////////////////////////////////////////////////////////////////
  // One arbiter per bank
  ////////////////////////////////////////////////////////////////////////////

  for (genvar b = 0; b < `VRF_NR_BANKS; b++) begin : gen_bank
    logic [3:0] arb_req;
    logic [3:0] arb_gnt;

    // Writers are routed by the bank bits of their address
    assign arb_req[vrf_access_pkg::MST_OPQ_A] = bank_req_a[b];
    assign arb_req[vrf_access_pkg::MST_ALU]   =
      alu_req_i && (alu_addr_i[`VRF_BANK_IDX_W-1:0] == `VRF_BANK_IDX_W'(b));
    assign arb_req[vrf_access_pkg::MST_OPQ_B] = bank_req_b[b];
    assign arb_req[vrf_access_pkg::MST_LDU]   =
      ldu_q_valid && (ldu_q_addr[`VRF_BANK_IDX_W-1:0] == `VRF_BANK_IDX_W'(b));

    bank_arbiter i_bank_arbiter (
      .clk_i, .rst_ni,
      .req_i(arb_req), .rd_row_a_i(row_a), .rd_row_b_i(row_b),
      .wr_row_alu_i(alu_addr_i[`VRF_ADDR_W-1:`VRF_BANK_IDX_W]),
      .wr_row_ldu_i(ldu_q_addr[`VRF_ADDR_W-1:`VRF_BANK_IDX_W]),
      .wdata_alu_i(alu_wdata_i), .wdata_ldu_i(ldu_q_wdata),
      .be_alu_i(alu_be_i), .be_ldu_i(ldu_q_be), .gnt_o(arb_gnt),
      .vrf_req_o(vrf_req_o[b]), .vrf_addr_o(vrf_addr_o[b]), .vrf_wen_o(vrf_wen_o[b]),
      .vrf_wdata_o(vrf_wdata_o[b]), .vrf_be_o(vrf_be_o[b]), .vrf_tgt_o(vrf_tgt_o[b])
    );

    assign bank_gnt_a[b]   = arb_gnt[vrf_access_pkg::MST_OPQ_A];
    assign alu_gnt_bank[b] = arb_gnt[vrf_access_pkg::MST_ALU];
    assign bank_gnt_b[b]   = arb_gnt[vrf_access_pkg::MST_OPQ_B];
    assign ldu_gnt_bank[b] = arb_gnt[vrf_access_pkg::MST_LDU];
  end

  // Writers hit one bank, so OR the grants back
  assign alu_gnt_o   = |alu_gnt_bank;
  assign ldu_q_ready = |ldu_gnt_bank;

endmodule
